/* sources.f */
+incdir+include
verilog/dside_pkg.sv
verilog/dside_mem.sv
verilog/dside_access_tracker.sv
verilog/dside_trace_fifo.sv
verilog/dside_trace_apb.sv
verilog/dside_trace_top.sv
tb/tb_dside_trace.sv

/* include/tb_dside_checks.svh */
// Testbench helpers for the data-side tracer.
// Memory bus and APB drivers, typed compare tasks.

`ifndef TB_DSIDE_CHECKS_SVH
`define TB_DSIDE_CHECKS_SVH

// ------------------------------
// Compare tasks
// ------------------------------

function automatic string rec_text(input dside_rec_t r);
  return $sformatf("store=%0b addr=0x%08h be=0x%h data=0x%08h err=%0b",
                   r.store, r.addr, r.be, r.data, r.err);
endfunction

task automatic check_rec(input dside_rec_t got, input dside_rec_t exp);
  if (got !== exp) begin
    stop_on_error($sformatf("record got %s, expected %s", rec_text(got), rec_text(exp)));
  end
endtask

task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
  if (got !== exp) begin
    stop_on_error($sformatf("%s got 0x%08h, expected 0x%08h", what, got, exp));
  end
endtask

task automatic check_flag(input logic got, input logic exp, input string what);
  if (got !== exp) begin
    stop_on_error($sformatf("%s got %0b, expected %0b", what, got, exp));
  end
endtask

// ------------------------------
// Drivers
// ------------------------------

// One request, then wait for its response.
task automatic bus_access(input logic we, input logic [31:0] addr, input logic [3:0] be,
                          input logic [31:0] wdata, output logic [31:0] rdata,
                          output logic err);
  int unsigned waits;
  @(posedge clk);
  #1;
  dmem_req   = 1'b1;
  dmem_we    = we;
  dmem_addr  = addr;
  dmem_be    = be;
  dmem_wdata = wdata;
  @(negedge clk);
  check_flag(dmem_gnt, 1'b1, "grant in the request cycle");
  @(posedge clk);
  #1;
  dmem_req = 1'b0;
  waits    = 0;
  @(negedge clk);
  while (!dmem_rvalid && waits < 4) begin
    waits++;
    @(negedge clk);
  end
  check_word(waits, 32'd0, "extra cycles from grant to rvalid");
  rdata = dmem_rdata;
  err   = dmem_err;
endtask

// Setup phase, then access phase until pready.
task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic slverr);
  int unsigned waits;
  @(posedge clk);
  #1;
  apb = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
  @(posedge clk);
  #1;
  apb.penable = 1'b1;
  waits       = 0;
  @(negedge clk);
  while (!pready && waits < 4) begin
    waits++;
    @(negedge clk);
  end
  check_flag(pready, 1'b1, "pready in the access phase");
  rdata  = prdata;
  slverr = pslverr;
  @(posedge clk);
  #1;
  apb = '0;
endtask

task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
  logic err;
  apb_access(1'b0, addr, 32'h0, data, err);
  check_flag(err, 1'b0, "pslverr on read");
endtask

task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
  logic [31:0] unused;
  logic        err;
  apb_access(1'b1, addr, data, unused, err);
  check_flag(err, 1'b0, "pslverr on write");
endtask

`endif

/* tb/tb_dside_trace.sv */
// Testbench for the data-side bus tracer.
// Directed tests over the memory bus and the APB trace readout.

`timescale 1ns/100ps
`default_nettype none

module tb_dside_trace;

  import dside_pkg::*;

  localparam int unsigned MemWords  = 256;
  localparam int unsigned FifoDepth = 8;
  // Reset, then each test in order, then margin.
  localparam int unsigned TimeoutCycles = 5 + 12 + 180 + 69 + 63 + 142 + 21 + 100;

  logic        clk;
  logic        rst_n;
  logic        dmem_req, dmem_we, dmem_gnt, dmem_rvalid, dmem_err;
  logic [31:0] dmem_addr, dmem_wdata, dmem_rdata, prdata;
  logic [3:0]  dmem_be;
  logic        pready, pslverr;
  apb_req_t    apb;

  // Reference model.
  logic [31:0] ref_mem [MemWords];
  dside_rec_t  exp_q [$];
  logic        exp_ovf;
  logic [31:0] exp_loads, exp_stores, exp_errors;
  logic [31:0] used_addr [4];
  logic [15:0] lfsr_q;
  int unsigned cycles = 0;

  dside_trace_top #(
    .MemWords  (MemWords),
    .FifoDepth (FifoDepth)
  ) u_dside_trace_top (
    .clk_i (clk), .rst_ni (rst_n),
    .dmem_req_i (dmem_req), .dmem_we_i (dmem_we), .dmem_addr_i (dmem_addr),
    .dmem_be_i (dmem_be), .dmem_wdata_i (dmem_wdata), .dmem_gnt_o (dmem_gnt),
    .dmem_rvalid_o (dmem_rvalid), .dmem_rdata_o (dmem_rdata), .dmem_err_o (dmem_err),
    .apb_i (apb), .prdata_o (prdata), .pready_o (pready), .pslverr_o (pslverr)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == TimeoutCycles) begin
      $display("Timeout: the run took more than %0d cycles", TimeoutCycles);
      $display("*** TEST FAILED ***");
      $fatal(1, "Simulation stopped by the timeout");
    end
  end

  task automatic stop_on_error(input string msg);
    $display("FAIL at %0t ns: %s", $time, msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "Stopped at the first failing check");
  endtask

  `include "tb_dside_checks.svh"

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic rand_bits(input int unsigned n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      val    = {val[30:0], lfsr_q[0]};
      lfsr_q = lfsr_step(lfsr_q);
    end
  endtask

  // ------------------------------
  // Model and readout
  // ------------------------------

  // Applies one access to the model and queues its record, or marks a drop.
  task automatic expect_access(input logic we, input logic [31:0] addr, input logic [3:0] be,
                               input logic [31:0] wdata, output logic [31:0] rdata,
                               output logic err);
    logic [29:0] idx;
    dside_rec_t  rec;
    idx   = addr[31:2];
    err   = (idx >= MemWords);
    rdata = '0;
    if (!err && we) begin
      for (int b = 0; b < 4; b++) begin
        if (be[b]) ref_mem[idx][8*b +: 8] = wdata[8*b +: 8];
      end
    end else if (!err) begin
      rdata = ref_mem[idx];
    end
    rec = '{store: we, addr: addr, be: be, data: we ? wdata : rdata, err: err};
    exp_stores = exp_stores + we;
    exp_loads  = exp_loads + !we;
    exp_errors = exp_errors + err;
    if (exp_q.size() < FifoDepth) begin
      exp_q.push_back(rec);
    end else begin
      exp_ovf = 1'b1;
    end
  endtask

  task automatic do_access(input logic we, input logic [31:0] addr, input logic [3:0] be,
                           input logic [31:0] wdata);
    logic [31:0] exp_rdata, got_rdata;
    logic        exp_err, got_err;
    expect_access(we, addr, be, wdata, exp_rdata, exp_err);
    bus_access(we, addr, be, wdata, got_rdata, got_err);
    check_flag(got_err, exp_err, "bus error flag");
    if (!we) check_word(got_rdata, exp_rdata, "load data");
  endtask

  // Oldest record first.
  task automatic drain_records();
    dside_rec_t  got;
    logic [31:0] addr, data, info;
    while (exp_q.size() > 0) begin
      apb_read(REG_ADDR, addr);
      apb_read(REG_DATA, data);
      apb_read(REG_INFO, info);
      got = '{store: info[4], addr: addr, be: info[3:0], data: data, err: info[5]};
      check_rec(got, exp_q.pop_front());
      apb_write(REG_POP, 32'h0);
    end
  endtask

  task automatic check_status();
    logic [31:0] got;
    logic [7:0]  count;
    count = 8'(exp_q.size());
    apb_read(REG_STATUS, got);
    check_word(got, {22'b0, exp_ovf, (count == 8'd0), count}, "STATUS");
  endtask

  task automatic check_counters();
    logic [31:0] got;
    apb_read(REG_LOADS, got);
    check_word(got, exp_loads, "LOADS");
    apb_read(REG_STORES, got);
    check_word(got, exp_stores, "STORES");
    apb_read(REG_ERRORS, got);
    check_word(got, exp_errors, "ERRORS");
  endtask

  // ------------------------------
  // Tests
  // ------------------------------

  task automatic test_reset();
    check_status();
    check_counters();
  endtask

  // Full-word store, masked store, load, per address.
  task automatic test_store_load();
    logic [31:0] r, data;
    for (int i = 0; i < 4; i++) begin
      rand_bits(6, r);
      used_addr[i] = {22'b0, r[5:0], 2'(i), 2'b00};
      rand_bits(32, data);
      do_access(1'b1, used_addr[i], 4'hF, data);
      rand_bits(4, r);
      rand_bits(32, data);
      do_access(1'b1, used_addr[i], r[3:0], data);
      do_access(1'b0, used_addr[i], 4'hF, 32'h0);
      drain_records();
    end
    check_status();
    check_counters();
  endtask

  task automatic test_back_to_back();
    logic        we [4];
    logic [31:0] addr [4];
    logic [3:0]  be [4];
    logic [31:0] wdata [4];
    logic [31:0] exp_rdata [4];
    logic        exp_err [4];
    logic [31:0] r;
    we   = '{1'b1, 1'b0, 1'b0, 1'b1};
    addr = '{used_addr[0], used_addr[0], used_addr[1], used_addr[2]};
    for (int i = 0; i < 4; i++) begin
      rand_bits(4, r);
      be[i] = r[3:0];
      rand_bits(32, wdata[i]);
      expect_access(we[i], addr[i], be[i], wdata[i], exp_rdata[i], exp_err[i]);
    end
    @(posedge clk);
    for (int i = 0; i <= 4; i++) begin
      #1;
      dmem_req = (i < 4);
      if (i < 4) begin
        dmem_we    = we[i];
        dmem_addr  = addr[i];
        dmem_be    = be[i];
        dmem_wdata = wdata[i];
      end
      @(negedge clk);
      check_flag(dmem_gnt, (i < 4), "grant in back-to-back burst");
      check_flag(dmem_rvalid, (i > 0), "rvalid one cycle after grant");
      if (i > 0) begin
        check_flag(dmem_err, exp_err[i-1], "burst error flag");
        if (!we[i-1]) check_word(dmem_rdata, exp_rdata[i-1], "burst load data");
      end
      @(posedge clk);
    end
    drain_records();
    // No record left over from the burst.
    check_status();
    check_counters();
  endtask

  // Out-of-range word aliases used_addr[0] in the low index bits.
  task automatic test_error();
    logic [31:0] bad, data;
    bad = used_addr[0] + MemWords * 4;
    rand_bits(32, data);
    do_access(1'b1, bad, 4'hF, data);
    do_access(1'b0, bad, 4'hF, 32'h0);
    do_access(1'b0, used_addr[0], 4'hF, 32'h0);
    drain_records();
    check_counters();
    apb_write(REG_STORES, 32'h0);
    exp_loads  = '0;
    exp_stores = '0;
    exp_errors = '0;
    check_counters();
  endtask

  task automatic test_overflow();
    for (int i = 0; i < FifoDepth + 3; i++) begin
      do_access(1'b0, used_addr[i % 4], 4'hF, 32'h0);
    end
    check_status();
    check_counters();
    drain_records();
    check_status();
    apb_write(REG_STATUS, 32'h0);
    exp_ovf = 1'b0;
    check_status();
  endtask

  task automatic test_apb_errors();
    logic [31:0] unused;
    logic        err;
    apb_access(1'b0, 8'h20, 32'h0, unused, err);
    check_flag(err, 1'b1, "pslverr on unmapped offset");
    check_status();
    apb_write(REG_POP, 32'h0);
    check_status();
    check_counters();
  endtask

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    dmem_req   = 1'b0;
    dmem_we    = 1'b0;
    dmem_addr  = '0;
    dmem_be    = '0;
    dmem_wdata = '0;
    apb        = '0;
    lfsr_q     = 16'd12121;
    exp_ovf    = 1'b0;
    exp_loads  = '0;
    exp_stores = '0;
    exp_errors = '0;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    test_reset();
    test_store_load();
    test_back_to_back();
    test_error();
    test_overflow();
    test_apb_errors();
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/dside_access_tracker.sv */
// Access tracker for the data-side bus.
// Pairs each granted request with its response and forms one trace record.

`timescale 1ns/100ps
`default_nettype none

module dside_access_tracker (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  input  logic                   dmem_req_i,
  input  logic                   dmem_gnt_i,
  input  logic                   dmem_we_i,
  input  logic [31:0]            dmem_addr_i,
  input  logic [3:0]             dmem_be_i,
  input  logic [31:0]            dmem_wdata_i,
  input  logic                   dmem_rvalid_i,
  input  logic [31:0]            dmem_rdata_i,
  input  logic                   dmem_err_i,

  input  logic                   fifo_full_i,

  output logic                   rec_valid_o,
  output dside_pkg::dside_rec_t  rec_o,
  output logic                   drop_o
);

  import dside_pkg::*;

  logic        granted;
  logic        outstanding_q;
  logic        store_q;
  logic [31:0] addr_q;
  logic [3:0]  be_q;
  logic [31:0] wdata_q;

  assign granted = dmem_req_i && dmem_gnt_i;

  // Request side of the outstanding access.
  always_ff @(posedge clk_i) begin
    if (granted) begin
      store_q <= dmem_we_i;
      addr_q  <= dmem_addr_i;
      be_q    <= dmem_be_i;
      wdata_q <= dmem_wdata_i;
    end
  end

  // A new grant may land in the same cycle as the previous response.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      outstanding_q <= 1'b0;
    end else if (granted) begin
      outstanding_q <= 1'b1;
    end else if (dmem_rvalid_i) begin
      outstanding_q <= 1'b0;
    end
  end

  // ------------------------------
  // Record build
  // ------------------------------

  always_comb begin
    rec_o       = '0;
    rec_o.store = store_q;
    rec_o.addr  = addr_q;
    rec_o.be    = be_q;
    rec_o.data  = store_q ? wdata_q : dmem_rdata_i;
    rec_o.err   = dmem_err_i;
  end

  // Full FIFO turns the record into a drop.
  assign rec_valid_o = dmem_rvalid_i && !fifo_full_i;
  assign drop_o      = dmem_rvalid_i && fifo_full_i;

  rvalid_outstanding_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    dmem_rvalid_i |-> outstanding_q
  );

endmodule

`default_nettype wire

/* verilog/dside_mem.sv */
// Data memory on a request/grant/rvalid bus.
// Grants at once, answers one cycle later, flags out-of-range words.

`timescale 1ns/100ps
`default_nettype none

module dside_mem #(
  parameter int unsigned MemWords = 256
) (
  input  logic        clk_i,
  input  logic        rst_ni,

  input  logic        dmem_req_i,
  input  logic        dmem_we_i,
  input  logic [31:0] dmem_addr_i,
  input  logic [3:0]  dmem_be_i,
  input  logic [31:0] dmem_wdata_i,

  output logic        dmem_gnt_o,
  output logic        dmem_rvalid_o,
  output logic [31:0] dmem_rdata_o,
  output logic        dmem_err_o
);

  localparam int unsigned IdxW = (MemWords > 1) ? $clog2(MemWords) : 1;

  logic [31:0]     mem_q [MemWords];
  logic [IdxW-1:0] word_idx;
  logic            in_range;
  logic            rvalid_q;
  logic            err_q;
  logic [31:0]     rdata_q;

  // No stall, every request is granted.
  assign dmem_gnt_o = dmem_req_i;

  assign word_idx = dmem_addr_i[IdxW+1:2];
  assign in_range = (dmem_addr_i[31:2] < 30'(MemWords));

  // Byte-masked store.
  always_ff @(posedge clk_i) begin
    if (dmem_req_i && dmem_we_i && in_range) begin
      for (int b = 0; b < 4; b++) begin
        if (dmem_be_i[b]) begin
          mem_q[word_idx][8*b +: 8] <= dmem_wdata_i[8*b +: 8];
        end
      end
    end
  end

  // Response, one cycle after grant.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      rvalid_q <= dmem_req_i;
      err_q    <= dmem_req_i && !in_range;
    end
  end

  // Loads return the whole word, errors and stores return zero.
  always_ff @(posedge clk_i) begin
    if (dmem_req_i) begin
      rdata_q <= (in_range && !dmem_we_i) ? mem_q[word_idx] : '0;
    end
  end

  assign dmem_rvalid_o = rvalid_q;
  assign dmem_err_o    = err_q;
  assign dmem_rdata_o  = rdata_q;

  // Every response belongs to a grant one cycle earlier.
  rvalid_after_gnt_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    dmem_rvalid_o |-> $past(dmem_req_i && dmem_gnt_o)
  );

endmodule

`default_nettype wire

/* verilog/dside_pkg.sv */
// Data-side trace package.
// Shared trace record and APB request types and the register map.

`default_nettype none

package dside_pkg;

  // ------------------------------
  // Trace record
  // ------------------------------

  // One completed data-side access.
  // Data is the store data for a store and the read data for a load.
  typedef struct packed {
    logic        store;
    logic [31:0] addr;
    logic [3:0]  be;
    logic [31:0] data;
    logic        err;
  } dside_rec_t;

  // ------------------------------
  // APB request
  // ------------------------------

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  // ------------------------------
  // Register offsets
  // ------------------------------

  localparam logic [7:0] REG_STATUS = 8'h00;
  localparam logic [7:0] REG_ADDR   = 8'h04;
  localparam logic [7:0] REG_DATA   = 8'h08;
  localparam logic [7:0] REG_INFO   = 8'h0C;
  localparam logic [7:0] REG_POP    = 8'h10;
  localparam logic [7:0] REG_LOADS  = 8'h14;
  localparam logic [7:0] REG_STORES = 8'h18;
  localparam logic [7:0] REG_ERRORS = 8'h1C;

endpackage

`default_nettype wire

/* verilog/dside_trace_apb.sv */
// APB register block for the trace FIFO.
// Shows the head record, pops on command, counts accesses and overflow.

`timescale 1ns/100ps
`default_nettype none

module dside_trace_apb #(
  parameter int unsigned FifoDepth = 8
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,

  input  dside_pkg::apb_req_t                  apb_i,

  input  logic                                 rec_valid_i,
  input  logic                                 rec_store_i,
  input  logic                                 rec_err_i,
  input  logic                                 drop_i,

  input  dside_pkg::dside_rec_t                head_i,
  input  logic                                 empty_i,
  input  logic [$clog2(FifoDepth+1)-1:0]       count_i,

  output logic [31:0]                          prdata_o,
  output logic                                 pready_o,
  output logic                                 pslverr_o,
  output logic                                 pop_o
);

  import dside_pkg::*;

  logic        access;
  logic        mapped;
  logic        wr_en;
  logic        done;
  logic        cnt_clr;
  logic        overflow_q;
  logic [31:0] loads_q;
  logic [31:0] stores_q;
  logic [31:0] errors_q;
  logic [31:0] status;

  assign access = apb_i.psel && apb_i.penable;

  always_comb begin
    case (apb_i.paddr)
      REG_STATUS, REG_ADDR, REG_DATA, REG_INFO,
      REG_POP, REG_LOADS, REG_STORES, REG_ERRORS: mapped = 1'b1;
      default:                                     mapped = 1'b0;
    endcase
  end

  assign wr_en     = access && apb_i.pwrite && mapped;
  assign pready_o  = access;
  assign pslverr_o = access && !mapped;

  // Pop is ignored on an empty FIFO.
  assign pop_o = wr_en && (apb_i.paddr == REG_POP) && !empty_i;

  // ------------------------------
  // Counters and overflow
  // ------------------------------

  // Drops still count as completed accesses.
  assign done    = rec_valid_i || drop_i;
  assign cnt_clr = wr_en && ((apb_i.paddr == REG_LOADS) || (apb_i.paddr == REG_STORES) ||
                             (apb_i.paddr == REG_ERRORS));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      loads_q  <= '0;
      stores_q <= '0;
      errors_q <= '0;
    end else if (cnt_clr) begin
      loads_q  <= '0;
      stores_q <= '0;
      errors_q <= '0;
    end else if (done) begin
      loads_q  <= loads_q + {31'b0, !rec_store_i};
      stores_q <= stores_q + {31'b0, rec_store_i};
      errors_q <= errors_q + {31'b0, rec_err_i};
    end
  end

  // A drop in the clearing cycle is a fresh loss, so set wins.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      overflow_q <= 1'b0;
    end else if (drop_i) begin
      overflow_q <= 1'b1;
    end else if (wr_en && (apb_i.paddr == REG_STATUS)) begin
      overflow_q <= 1'b0;
    end
  end

  // ------------------------------
  // Read mux
  // ------------------------------

  always_comb begin
    status      = '0;
    status[7:0] = 8'(count_i);
    status[8]   = empty_i;
    status[9]   = overflow_q;
  end

  always_comb begin
    prdata_o = '0;
    if (access && !apb_i.pwrite) begin
      case (apb_i.paddr)
        REG_STATUS: prdata_o = status;
        REG_ADDR:   prdata_o = head_i.addr;
        REG_DATA:   prdata_o = head_i.data;
        REG_INFO:   prdata_o = {26'b0, head_i.err, head_i.store, head_i.be};
        REG_LOADS:  prdata_o = loads_q;
        REG_STORES: prdata_o = stores_q;
        REG_ERRORS: prdata_o = errors_q;
        default:    prdata_o = '0;
      endcase
    end
  end

  penable_with_psel_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni) apb_i.penable |-> apb_i.psel
  );

endmodule

`default_nettype wire

/* verilog/dside_trace_fifo.sv */
// Trace record FIFO.
// Circular buffer with full, empty and occupancy count.

`timescale 1ns/100ps
`default_nettype none

module dside_trace_fifo #(
  parameter int unsigned FifoDepth = 8
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,

  input  logic                                 push_i,
  input  dside_pkg::dside_rec_t                push_data_i,
  input  logic                                 pop_i,

  output dside_pkg::dside_rec_t                head_o,
  output logic                                 empty_o,
  output logic                                 full_o,
  output logic [$clog2(FifoDepth+1)-1:0]       count_o
);

  import dside_pkg::*;

  localparam int unsigned PtrW = $clog2(FifoDepth);
  localparam int unsigned CntW = $clog2(FifoDepth + 1);

  dside_rec_t      buf_q [FifoDepth];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic            do_push;
  logic            do_pop;

  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      buf_q[wr_ptr_q] <= push_data_i;
    end
  end

  // Depth is a power of two, so pointers wrap on their own.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  assign head_o  = buf_q[rd_ptr_q];
  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == CntW'(FifoDepth));
  assign count_o = count_q;

  no_push_full_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni) push_i |-> !full_o
  );

  no_pop_empty_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni) pop_i |-> !empty_o
  );

endmodule

`default_nettype wire

/* verilog/dside_trace_top.sv */
// Data-side bus tracer top level.
// Memory, access tracker, trace FIFO and APB readout.

`timescale 1ns/100ps
`default_nettype none

module dside_trace_top #(
  parameter int unsigned MemWords  = 256,
  parameter int unsigned FifoDepth = 8
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,

  input  logic                 dmem_req_i,
  input  logic                 dmem_we_i,
  input  logic [31:0]          dmem_addr_i,
  input  logic [3:0]           dmem_be_i,
  input  logic [31:0]          dmem_wdata_i,
  output logic                 dmem_gnt_o,
  output logic                 dmem_rvalid_o,
  output logic [31:0]          dmem_rdata_o,
  output logic                 dmem_err_o,

  input  dside_pkg::apb_req_t  apb_i,
  output logic [31:0]          prdata_o,
  output logic                 pready_o,
  output logic                 pslverr_o
);

  import dside_pkg::*;

  localparam int unsigned CntW = $clog2(FifoDepth + 1);

  dside_rec_t      rec;
  dside_rec_t      head;
  logic            rec_valid;
  logic            drop;
  logic            full;
  logic            empty;
  logic            pop;
  logic [CntW-1:0] count;

  dside_mem #(
    .MemWords (MemWords)
  ) u_dside_mem (
    .clk_i, .rst_ni,
    .dmem_req_i, .dmem_we_i, .dmem_addr_i, .dmem_be_i, .dmem_wdata_i,
    .dmem_gnt_o, .dmem_rvalid_o, .dmem_rdata_o, .dmem_err_o
  );

  dside_access_tracker u_dside_access_tracker (
    .clk_i, .rst_ni,
    .dmem_req_i, .dmem_gnt_i (dmem_gnt_o), .dmem_we_i, .dmem_addr_i, .dmem_be_i,
    .dmem_wdata_i, .dmem_rvalid_i (dmem_rvalid_o), .dmem_rdata_i (dmem_rdata_o),
    .dmem_err_i (dmem_err_o), .fifo_full_i (full),
    .rec_valid_o (rec_valid), .rec_o (rec), .drop_o (drop)
  );

  dside_trace_fifo #(
    .FifoDepth (FifoDepth)
  ) u_dside_trace_fifo (
    .clk_i, .rst_ni,
    .push_i (rec_valid), .push_data_i (rec), .pop_i (pop),
    .head_o (head), .empty_o (empty), .full_o (full), .count_o (count)
  );

  dside_trace_apb #(
    .FifoDepth (FifoDepth)
  ) u_dside_trace_apb (
    .clk_i, .rst_ni, .apb_i,
    .rec_valid_i (rec_valid), .rec_store_i (rec.store), .rec_err_i (rec.err),
    .drop_i (drop), .head_i (head), .empty_i (empty), .count_i (count),
    .prdata_o, .pready_o, .pslverr_o, .pop_o (pop)
  );

endmodule

`default_nettype wire
